//--- src/vtp_pkg.sv
// Shared definitions for the virtual-to-physical translation shim
// Address widths, page table geometry, common types and walker states

package vtp_pkg;

    // ======================================================================
    // Address and line geometry
    // ======================================================================

    localparam int LINE_BITS = 128;
    localparam int VA_LINE_BITS = 32;

    // Line offset within a page, kept unchanged by translation
    localparam int PAGE_OFFSET_BITS = 6;

    // The page table hash index is the low part of the virtual page,
    // the tag is the rest of it
    localparam int PT_HASH_BITS = 8;
    localparam int PT_TAG_BITS = 18;
    localparam int PA_IDX_BITS = 20;
    localparam int PT_IDX_BITS = 10;

    // Request metadata, with one bit kept back to mark walker reads
    localparam int MDATA_BITS = 8;
    localparam int RESERVED_MDATA_BIT = 7;

    // Page table line layout
    // The next-line index sits in the low bits and the entries follow it,
    // each one a tag in its upper bits over a physical index in its low bits
    localparam int PTE_BYTES = 5;
    localparam int PTES_PER_LINE = 2;

    // ======================================================================
    // Types
    // ======================================================================

    typedef logic [VA_LINE_BITS-1:0] line_addr_t;
    typedef logic [PT_TAG_BITS+PT_HASH_BITS-1:0] va_page_t;
    typedef logic [PA_IDX_BITS-1:0] pa_idx_t;
    typedef logic [PT_IDX_BITS-1:0] pt_idx_t;
    typedef logic [PT_TAG_BITS-1:0] pt_tag_t;
    typedef logic [LINE_BITS-1:0] line_data_t;
    typedef logic [MDATA_BITS-1:0] mdata_t;

    // Miss handler FSM
    typedef enum logic [2:0]
    {
        IDLE,
        READ_REQ,
        READ_RSP,
        SEARCH,
        INSERT,
        BUBBLE,
        ERROR
    } walker_state_t;

endpackage

//--- src/tlb_cache.sv
// Set-associative TLB holding virtual page to physical index translations
// Clears itself after reset and fills one round-robin way per insertion

`timescale 1ns/10ps

module tlb_cache #(
    parameter int TLB_SETS = 64,
    parameter int TLB_WAYS = 2
)
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              lookup_en,
    input  vtp_pkg::va_page_t lookup_page,
    output logic              lookup_rdy,
    output logic              hit,
    output vtp_pkg::pa_idx_t  hit_pa,
    output logic              miss,
    output vtp_pkg::va_page_t miss_page,
    input  logic              insert_en,
    input  vtp_pkg::va_page_t insert_page,
    input  vtp_pkg::pa_idx_t  insert_pa
);

    localparam int PAGE_BITS = $bits(vtp_pkg::va_page_t);
    localparam int SET_BITS = $clog2(TLB_SETS);
    localparam int WAY_BITS = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1;

    // The TLB tag is whatever the set index leaves of the page, which is
    // not the same split as the host page table hash
    localparam int TAG_BITS = PAGE_BITS - SET_BITS;

    // Entry layout is valid bit, tag, physical index
    localparam int ENTRY_BITS = 1 + TAG_BITS + vtp_pkg::PA_IDX_BITS;

    logic [SET_BITS:0]     init_idx;
    logic                  initialized;
    logic [SET_BITS-1:0]   rd_idx;
    logic [SET_BITS-1:0]   wr_idx;
    logic [ENTRY_BITS-1:0] wr_entry;
    logic [TLB_WAYS-1:0]   way_wen;
    logic [TLB_WAYS-1:0]   way_hit;
    vtp_pkg::pa_idx_t      way_pa [TLB_WAYS];
    logic [WAY_BITS-1:0]   rr_ptr [TLB_SETS];
    logic                  did_lookup;
    vtp_pkg::va_page_t     page_q;

    // ======================================================================
    // Initialization sweep
    // ======================================================================

    // The top bit of the counter sets once every set has been written
    assign initialized = init_idx[SET_BITS];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            init_idx <= '0;
        end
        else if (!initialized)
        begin
            init_idx <= init_idx + 1'b1;
        end
    end

    // No lookups while sweeping, or while an insertion owns the write port
    assign lookup_rdy = initialized && !insert_en;

    // ======================================================================
    // Storage, one array per way
    // ======================================================================

    assign rd_idx = lookup_page[SET_BITS-1:0];
    assign wr_idx = initialized ? insert_page[SET_BITS-1:0] : init_idx[SET_BITS-1:0];

    // The sweep writes all zeros, which leaves every entry invalid
    assign wr_entry = initialized ?
                      {1'b1, insert_page[PAGE_BITS-1:SET_BITS], insert_pa} : '0;

    always_comb
    begin
        for (int w = 0; w < TLB_WAYS; w++)
        begin
            // Only the way under the set's pointer takes an insertion
            way_wen[w] = !initialized || (insert_en && (rr_ptr[wr_idx] == WAY_BITS'(w)));
        end
    end

    for (genvar w = 0; w < TLB_WAYS; w++)
    begin : g_way
        logic [ENTRY_BITS-1:0] mem [TLB_SETS];
        logic [ENTRY_BITS-1:0] rd_entry;

        always_ff @(posedge clk)
        begin
            if (way_wen[w])
            begin
                mem[wr_idx] <= wr_entry;
            end
            // Read data lines up with the latched page one cycle later
            rd_entry <= mem[rd_idx];
        end

        assign way_hit[w] = rd_entry[ENTRY_BITS-1] &&
                            (rd_entry[ENTRY_BITS-2 -: TAG_BITS] == page_q[PAGE_BITS-1:SET_BITS]);
        assign way_pa[w] = rd_entry[vtp_pkg::PA_IDX_BITS-1:0];
    end

    // ======================================================================
    // Tag match
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            did_lookup <= 1'b0;
        end
        else
        begin
            did_lookup <= lookup_en;
        end
        page_q <= lookup_page;
    end

    always_comb
    begin
        hit_pa = '0;
        // A page lives in at most one way, so the OR picks out the hit
        for (int w = 0; w < TLB_WAYS; w++)
        begin
            if (way_hit[w])
            begin
                hit_pa = hit_pa | way_pa[w];
            end
        end
    end

    assign hit = did_lookup && (|way_hit);
    assign miss = did_lookup && !(|way_hit);

    // The walker picks up the page that missed from here
    assign miss_page = page_q;

    // ======================================================================
    // Round-robin victim pointers
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (!initialized)
        begin
            rr_ptr[wr_idx] <= '0;
        end
        else if (insert_en)
        begin
            // Wrap after the last way
            rr_ptr[wr_idx] <= (rr_ptr[wr_idx] == WAY_BITS'(TLB_WAYS - 1)) ?
                              '0 : rr_ptr[wr_idx] + 1'b1;
        end
    end

endmodule

//--- src/pt_walker.sv
// Page table walker for TLB misses
// Reads hashed, linked page table lines from host memory and inserts hits

`timescale 1ns/10ps

module pt_walker
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 miss,
    input  vtp_pkg::va_page_t    miss_page,
    input  logic                 pt_base_wr,
    input  vtp_pkg::line_addr_t  pt_base,
    input  logic                 mem_almost_full,
    input  logic                 walk_rsp_valid,
    input  vtp_pkg::line_data_t  walk_rsp_data,
    output logic                 walk_rd_valid,
    output vtp_pkg::line_addr_t  walk_rd_addr,
    output logic                 insert_en,
    output vtp_pkg::va_page_t    insert_page,
    output vtp_pkg::pa_idx_t     insert_pa,
    output logic                 translate_error
);

    localparam int PTE_BITS = 8 * vtp_pkg::PTE_BYTES;
    localparam int PTE_BASE_BIT = 16;
    localparam int NUM_BITS = $clog2(vtp_pkg::PTES_PER_LINE + 1);
    localparam int PAGE_BITS = $bits(vtp_pkg::va_page_t);

    vtp_pkg::walker_state_t state;
    vtp_pkg::line_addr_t    base_q;
    logic                   base_valid;
    vtp_pkg::va_page_t      page_q;
    vtp_pkg::pt_idx_t       line_idx;
    vtp_pkg::pt_idx_t       next_idx;
    vtp_pkg::line_data_t    pt_line;
    logic [NUM_BITS-1:0]    pte_num;
    vtp_pkg::pa_idx_t       found_pa;
    logic [PTE_BITS-1:0]    cur_pte;
    vtp_pkg::pt_tag_t       cur_tag;
    vtp_pkg::pt_tag_t       page_tag;

    // ======================================================================
    // Page table base register
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            base_valid <= 1'b0;
        end
        else if (pt_base_wr)
        begin
            base_valid <= 1'b1;
        end

        if (pt_base_wr)
        begin
            base_q <= pt_base;
        end
    end

    // ======================================================================
    // Miss FSM
    // ======================================================================

    // The line is shifted down one entry per search step, so the entry
    // under test always sits just above the next-line index
    assign cur_pte = pt_line[PTE_BASE_BIT +: PTE_BITS];
    // The tag fills the top of the entry, with spare bits below it
    assign cur_tag = cur_pte[PTE_BITS-1 -: vtp_pkg::PT_TAG_BITS];
    assign page_tag = page_q[PAGE_BITS-1:vtp_pkg::PT_HASH_BITS];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= vtp_pkg::IDLE;
        end
        else
        begin
            case (state)
                vtp_pkg::IDLE:
                begin
                    // The first line of a chain is the page's hash bucket
                    if (miss)
                    begin
                        page_q <= miss_page;
                        line_idx <= {{(vtp_pkg::PT_IDX_BITS - vtp_pkg::PT_HASH_BITS){1'b0}},
                                     miss_page[vtp_pkg::PT_HASH_BITS-1:0]};
                        state <= vtp_pkg::READ_REQ;
                    end
                end
                vtp_pkg::READ_REQ:
                begin
                    if (walk_rd_valid)
                    begin
                        state <= vtp_pkg::READ_RSP;
                    end
                end
                vtp_pkg::READ_RSP:
                begin
                    if (walk_rsp_valid)
                    begin
                        pt_line <= walk_rsp_data;
                        next_idx <= walk_rsp_data[vtp_pkg::PT_IDX_BITS-1:0];
                        pte_num <= '0;
                        state <= vtp_pkg::SEARCH;
                    end
                end
                vtp_pkg::SEARCH:
                begin
                    if (pte_num == NUM_BITS'(vtp_pkg::PTES_PER_LINE))
                    begin
                        // An exhausted line sends us along the chain or to its end
                        if (next_idx == '0)
                        begin
                            state <= vtp_pkg::ERROR;
                        end
                        else
                        begin
                            line_idx <= next_idx;
                            state <= vtp_pkg::READ_REQ;
                        end
                    end
                    else if (cur_tag == page_tag)
                    begin
                        found_pa <= cur_pte[vtp_pkg::PA_IDX_BITS-1:0];
                        state <= vtp_pkg::INSERT;
                    end
                    else if (cur_tag == '0)
                    begin
                        // An empty entry ends the list early
                        state <= vtp_pkg::ERROR;
                    end
                    else
                    begin
                        pt_line <= pt_line >> PTE_BITS;
                        pte_num <= pte_num + 1'b1;
                    end
                end
                vtp_pkg::INSERT:
                begin
                    state <= vtp_pkg::BUBBLE;
                end
                vtp_pkg::BUBBLE:
                begin
                    // Gives the TLB write a cycle to land before another miss
                    state <= vtp_pkg::IDLE;
                end
                default:
                begin
                    // ERROR holds until reset
                    state <= vtp_pkg::ERROR;
                end
            endcase
        end
    end

    // Reads wait for a base value and for room in the memory channel
    assign walk_rd_valid = (state == vtp_pkg::READ_REQ) && base_valid && !mem_almost_full;
    assign walk_rd_addr = base_q + vtp_pkg::line_addr_t'(line_idx);

    assign insert_en = (state == vtp_pkg::INSERT);
    assign insert_page = page_q;
    assign insert_pa = found_pa;
    assign translate_error = (state == vtp_pkg::ERROR);

endmodule

//--- src/req_pipe.sv
// Two-stage client request pipeline with retry rotation
// Rewrites virtual addresses, muxes walker reads and splits responses

`timescale 1ns/10ps

module req_pipe
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 req_valid,
    input  vtp_pkg::line_addr_t  req_addr,
    input  logic                 req_virtual,
    input  vtp_pkg::mdata_t      req_mdata,
    output logic                 req_deq,
    output logic                 lookup_en,
    output vtp_pkg::va_page_t    lookup_page,
    input  logic                 lookup_rdy,
    input  logic                 hit,
    input  vtp_pkg::pa_idx_t     hit_pa,
    input  logic                 mem_almost_full,
    input  logic                 walk_rd_valid,
    input  vtp_pkg::line_addr_t  walk_rd_addr,
    output logic                 mem_rd_valid,
    output vtp_pkg::line_addr_t  mem_rd_addr,
    output vtp_pkg::mdata_t      mem_rd_mdata,
    input  logic                 mem_rsp_valid,
    input  vtp_pkg::line_data_t  mem_rsp_data,
    input  vtp_pkg::mdata_t      mem_rsp_mdata,
    output logic                 rsp_valid,
    output vtp_pkg::line_data_t  rsp_data,
    output vtp_pkg::mdata_t      rsp_mdata,
    output logic                 walk_rsp_valid,
    output vtp_pkg::line_data_t  walk_rsp_data
);

    localparam int PAD_BITS = vtp_pkg::VA_LINE_BITS - vtp_pkg::PA_IDX_BITS -
                              vtp_pkg::PAGE_OFFSET_BITS;

    logic                s0_valid;
    vtp_pkg::line_addr_t s0_addr;
    logic                s0_virtual;
    vtp_pkg::mdata_t     s0_mdata;
    logic                s1_valid;
    vtp_pkg::line_addr_t s1_addr;
    logic                s1_virtual;
    vtp_pkg::mdata_t     s1_mdata;
    logic                fwd;
    logic                retry;
    logic                is_walk_rsp;

    // ======================================================================
    // Pipeline control
    // ======================================================================

    // The oldest request leaves only with a translation, room downstream
    // and no walker read competing for the channel
    assign fwd = s1_valid && (!s1_virtual || hit) && !mem_almost_full && !walk_rd_valid;
    assign retry = s1_valid && !fwd;

    // A rotated request owns stage 0, so the client waits that cycle
    assign req_deq = req_valid && !retry;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
        end
        else
        begin
            s0_valid <= retry ? 1'b1 : req_valid;
            s1_valid <= s0_valid;
        end

        if (retry)
        begin
            s0_addr <= s1_addr;
            s0_virtual <= s1_virtual;
            s0_mdata <= s1_mdata;
        end
        else
        begin
            s0_addr <= req_addr;
            s0_virtual <= req_virtual;
            s0_mdata <= req_mdata;
        end

        s1_addr <= s0_addr;
        s1_virtual <= s0_virtual;
        s1_mdata <= s0_mdata;
    end

    // Stage 0 feeds the TLB, and the answer arrives as the request reaches stage 1
    assign lookup_en = lookup_rdy && s0_valid && s0_virtual;
    assign lookup_page = s0_addr[vtp_pkg::VA_LINE_BITS-1:vtp_pkg::PAGE_OFFSET_BITS];

    // ======================================================================
    // Read channel
    // ======================================================================

    assign mem_rd_valid = fwd || walk_rd_valid;

    always_comb
    begin
        if (walk_rd_valid)
        begin
            mem_rd_addr = walk_rd_addr;
            mem_rd_mdata = '0;
            mem_rd_mdata[vtp_pkg::RESERVED_MDATA_BIT] = 1'b1;
        end
        else
        begin
            mem_rd_mdata = s1_mdata;
            // Page offset is the same on both sides of the translation
            if (s1_virtual)
            begin
                mem_rd_addr = {{PAD_BITS{1'b0}}, hit_pa,
                               s1_addr[vtp_pkg::PAGE_OFFSET_BITS-1:0]};
            end
            else
            begin
                mem_rd_addr = s1_addr;
            end
        end
    end

    // ======================================================================
    // Response split
    // ======================================================================

    assign is_walk_rsp = mem_rsp_mdata[vtp_pkg::RESERVED_MDATA_BIT];

    // Walker responses stay hidden from the client
    assign rsp_valid = mem_rsp_valid && !is_walk_rsp;
    assign rsp_data = mem_rsp_data;
    assign rsp_mdata = mem_rsp_mdata;

    assign walk_rsp_valid = mem_rsp_valid && is_walk_rsp;
    assign walk_rsp_data = mem_rsp_data;

endmodule

//--- src/vtp_shim.sv
// Virtual-to-physical translation shim for one host memory read channel
// Connects the request pipeline, the TLB and the page table walker

`timescale 1ns/10ps

module vtp_shim #(
    parameter int TLB_SETS = 64,
    parameter int TLB_WAYS = 2
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 req_valid,
    input  vtp_pkg::line_addr_t  req_addr,
    input  logic                 req_virtual,
    input  vtp_pkg::mdata_t      req_mdata,
    output logic                 req_deq,
    input  logic                 mem_almost_full,
    output logic                 mem_rd_valid,
    output vtp_pkg::line_addr_t  mem_rd_addr,
    output vtp_pkg::mdata_t      mem_rd_mdata,
    input  logic                 mem_rsp_valid,
    input  vtp_pkg::line_data_t  mem_rsp_data,
    input  vtp_pkg::mdata_t      mem_rsp_mdata,
    output logic                 rsp_valid,
    output vtp_pkg::line_data_t  rsp_data,
    output vtp_pkg::mdata_t      rsp_mdata,
    input  logic                 pt_base_wr,
    input  vtp_pkg::line_addr_t  pt_base,
    output logic                 translate_error
);

    // TLB lookup path
    logic                lookup_en;
    vtp_pkg::va_page_t   lookup_page;
    logic                lookup_rdy;
    logic                hit;
    vtp_pkg::pa_idx_t    hit_pa;
    logic                miss;
    vtp_pkg::va_page_t   miss_page;

    // Walker traffic
    logic                walk_rd_valid;
    vtp_pkg::line_addr_t walk_rd_addr;
    logic                walk_rsp_valid;
    vtp_pkg::line_data_t walk_rsp_data;
    logic                insert_en;
    vtp_pkg::va_page_t   insert_page;
    vtp_pkg::pa_idx_t    insert_pa;

    req_pipe u_req_pipe
    (
        .clk, .reset_n,
        .req_valid, .req_addr, .req_virtual, .req_mdata, .req_deq,
        .lookup_en, .lookup_page, .lookup_rdy, .hit, .hit_pa,
        .mem_almost_full, .walk_rd_valid, .walk_rd_addr,
        .mem_rd_valid, .mem_rd_addr, .mem_rd_mdata,
        .mem_rsp_valid, .mem_rsp_data, .mem_rsp_mdata,
        .rsp_valid, .rsp_data, .rsp_mdata,
        .walk_rsp_valid, .walk_rsp_data
    );

    tlb_cache #(
        .TLB_SETS(TLB_SETS),
        .TLB_WAYS(TLB_WAYS)
    ) u_tlb_cache
    (
        .clk, .reset_n,
        .lookup_en, .lookup_page, .lookup_rdy, .hit, .hit_pa,
        .miss, .miss_page,
        .insert_en, .insert_page, .insert_pa
    );

    pt_walker u_pt_walker
    (
        .clk, .reset_n,
        .miss, .miss_page, .pt_base_wr, .pt_base, .mem_almost_full,
        .walk_rsp_valid, .walk_rsp_data, .walk_rd_valid, .walk_rd_addr,
        .insert_en, .insert_page, .insert_pa, .translate_error
    );

endmodule

//--- tests/host_mem_model.sv
// Host memory responder for the translation shim testbench
// Serves page table lines and address-pattern data with random delay

`timescale 1ns/10ps

module host_mem_model
(
    input  logic         clk,
    input  logic         reset_n,
    input  logic         bp_en,
    input  logic         pt_wr,
    input  logic [31:0]  pt_wr_addr,
    input  logic [127:0] pt_wr_data,
    input  logic         mem_rd_valid,
    input  logic [31:0]  mem_rd_addr,
    input  logic [7:0]   mem_rd_mdata,
    output logic         mem_almost_full,
    output logic         mem_rsp_valid,
    output logic [127:0] mem_rsp_data,
    output logic [7:0]   mem_rsp_mdata
);

    integer       seed;
    int           cycle;
    int           burst_left;
    logic [127:0] pt_mem [logic [31:0]];
    logic [31:0]  pend_addr [$];
    logic [7:0]   pend_mdata [$];
    int           pend_due [$];

    initial
    begin
        seed = 69127;
        cycle = 0;
        burst_left = 0;
        mem_almost_full = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        mem_rsp_mdata = '0;
    end

    // Reads are captured on the rising edge, walker reads come back quickly
    always @(posedge clk)
    begin
        if (pt_wr)
            pt_mem[pt_wr_addr] = pt_wr_data;
        if (reset_n && mem_rd_valid)
        begin
            pend_addr.push_back(mem_rd_addr);
            pend_mdata.push_back(mem_rd_mdata);
            if (mem_rd_mdata[7])
                pend_due.push_back(cycle + 2);
            else
                pend_due.push_back(cycle + 1 + int'($unsigned($random(seed)) % 12));
        end
        cycle++;
    end

    // Responses and back-pressure change on the falling edge
    always @(negedge clk)
    begin
        mem_rsp_valid = 1'b0;
        for (int i = 0; i < pend_addr.size(); i++)
        begin
            if (pend_due[i] <= cycle)
            begin
                mem_rsp_valid = 1'b1;
                mem_rsp_mdata = pend_mdata[i];
                if (pend_mdata[i][7])
                    mem_rsp_data = pt_mem.exists(pend_addr[i]) ? pt_mem[pend_addr[i]] : '0;
                else
                    mem_rsp_data = {4{pend_addr[i]}};
                pend_addr.delete(i);
                pend_mdata.delete(i);
                pend_due.delete(i);
                break;
            end
        end
        if (!bp_en)
        begin
            mem_almost_full = 1'b0;
            burst_left = 0;
        end
        else if (burst_left == 0)
        begin
            // Start a new burst, either full or clear, of random length
            mem_almost_full = $random(seed) & 1;
            burst_left = 1 + int'($unsigned($random(seed)) % 6);
        end
        else
            burst_left--;
    end

endmodule

//--- tests/tb_vtp.sv
// Testbench for the translation shim
// Runs records from the data file against the DUT and a host memory model

`timescale 1ns/10ps

module tb_vtp;

    localparam int LIMIT = 3000;

    logic         clk = 1'b0;
    logic         reset_n;
    logic         req_valid, req_virtual, req_deq;
    logic [31:0]  req_addr, pt_base, mem_rd_addr, pt_wr_addr;
    logic [7:0]   req_mdata, mem_rd_mdata, mem_rsp_mdata, rsp_mdata;
    logic         mem_almost_full, mem_rd_valid, mem_rsp_valid, rsp_valid;
    logic [127:0] mem_rsp_data, rsp_data, pt_wr_data;
    logic         pt_base_wr, translate_error, bp_en, pt_wr, deq_q;
    logic [31:0]  base_val;
    logic [31:0]  issued_addr [logic [7:0]];
    logic [31:0]  exp_by_md [logic [7:0]];
    bit           pt_known [int];
    logic [7:0]   exp_mdata [$];
    logic [31:0]  exp_addr [$];
    int           issued_count, rsp_count, sent_count, walk_count;

    always #20 clk = ~clk;

    vtp_shim uut
    (
        .clk, .reset_n, .req_valid, .req_addr, .req_virtual, .req_mdata, .req_deq,
        .mem_almost_full, .mem_rd_valid, .mem_rd_addr, .mem_rd_mdata,
        .mem_rsp_valid, .mem_rsp_data, .mem_rsp_mdata,
        .rsp_valid, .rsp_data, .rsp_mdata, .pt_base_wr, .pt_base, .translate_error
    );

    host_mem_model mem_model
    (
        .clk, .reset_n, .bp_en, .pt_wr, .pt_wr_addr, .pt_wr_data,
        .mem_rd_valid, .mem_rd_addr, .mem_rd_mdata,
        .mem_almost_full, .mem_rsp_valid, .mem_rsp_data, .mem_rsp_mdata
    );

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp)
        begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic abort(input string what);
        $display("Failure: %s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // ======================================================================
    // Monitor that samples settled values at the rising edge
    // ======================================================================

    always @(posedge clk)
    begin
        deq_q = reset_n && req_deq;
        if (reset_n && mem_rd_valid)
        begin
            check("mem_almost_full", mem_almost_full, 1'b0);
            if (mem_rd_mdata[7])
            begin
                // Walker reads point at a known page table line
                check("walker mem_rd_mdata", mem_rd_mdata, 8'h80);
                check("walker line index", pt_known.exists(int'(mem_rd_addr - base_val)), 1);
                walk_count++;
            end
            else
            begin
                check("mem_rd_mdata reissued", issued_addr.exists(mem_rd_mdata), 0);
                issued_addr[mem_rd_mdata] = mem_rd_addr;
                issued_count++;
            end
        end
        if (reset_n && rsp_valid)
        begin
            // Client data is the expected address repeated across the line
            check("rsp_mdata reserved bit", rsp_mdata[7], 1'b0);
            check("rsp_mdata known", issued_addr.exists(rsp_mdata), 1);
            check("rsp_mdata expected", exp_by_md.exists(rsp_mdata), 1);
            check("rsp_data", rsp_data, {4{exp_by_md[rsp_mdata]}});
            rsp_count++;
        end
    end

    // ======================================================================
    // Stimulus tasks that run on the falling edge
    // ======================================================================

    task automatic send_request(input logic [31:0] addr, input logic virt, input logic [7:0] md);
        int waited;
        waited = 0;
        req_valid = 1'b1;
        req_addr = addr;
        req_virtual = virt;
        req_mdata = md;
        @(negedge clk);
        while (!deq_q)
        begin
            waited++;
            if (waited > LIMIT)
                abort("request was never dequeued");
            @(negedge clk);
        end
        req_valid = 1'b0;
        sent_count++;
    endtask

    // Waits until all sent requests are issued and answered, then checks them as a set
    task automatic drain_and_check();
        int waited;
        waited = 0;
        while (issued_count != sent_count || rsp_count != issued_count)
        begin
            waited++;
            if (waited > LIMIT)
                abort("requests were not all issued and answered");
            @(negedge clk);
        end
        for (int i = 0; i < exp_addr.size(); i++)
        begin
            check("mem_rd issued", issued_addr.exists(exp_mdata[i]), 1);
            check("mem_rd_addr", issued_addr[exp_mdata[i]], exp_addr[i]);
        end
        exp_addr.delete();
        exp_mdata.delete();
    endtask

    task automatic absent_page(input logic [31:0] addr, input logic [7:0] md);
        int waited;
        send_request(addr, 1'b1, md);
        waited = 0;
        while (!translate_error)
        begin
            waited++;
            if (waited > LIMIT)
                abort("translate_error did not rise for an absent page");
            @(negedge clk);
        end
        for (int i = 0; i < 40; i++)
            @(negedge clk);
        check("absent page issued", issued_addr.exists(md), 0);
    endtask

    initial
    begin
        integer       fd, n;
        string        kind, rest;
        logic [31:0]  a, b, e, t0, p0, t1, p1;
        logic [127:0] line;
        {req_valid, req_virtual, pt_base_wr, bp_en, pt_wr, deq_q} = '0;
        {req_addr, req_mdata, pt_base, pt_wr_addr, pt_wr_data, base_val} = '0;
        {issued_count, rsp_count, sent_count, walk_count} = '0;
        reset_n = 1'b0;
        for (int i = 0; i < 5; i++)
            @(negedge clk);
        reset_n = 1'b1;
        fd = $fopen("tests/vtp_tests.txt", "r");
        if (fd == 0)
            abort("cannot open tests/vtp_tests.txt");
        while ($fscanf(fd, "%s", kind) == 1)
        begin
            if (kind[0] == 8'h23)
                n = $fgets(rest, fd);
            else if (kind == "B")
            begin
                n = $fscanf(fd, " %h", a);
                base_val = a;
                pt_base = a;
                pt_base_wr = 1'b1;
                @(negedge clk);
                pt_base_wr = 1'b0;
            end
            else if (kind == "P")
            begin
                // Entry k sits at bit 16 + 40k, tag in its upper 18 bits
                n = $fscanf(fd, " %h %h %h %h %h %h", a, b, t0, p0, t1, p1);
                line = '0;
                line[9:0] = b[9:0];
                line[16 +: 20] = p0[19:0];
                line[16 + 22 +: 18] = t0[17:0];
                line[56 +: 20] = p1[19:0];
                line[56 + 22 +: 18] = t1[17:0];
                pt_known[int'(a)] = 1'b1;
                pt_wr_addr = base_val + a;
                pt_wr_data = line;
                pt_wr = 1'b1;
                @(negedge clk);
                pt_wr = 1'b0;
            end
            else if (kind == "R")
            begin
                n = $fscanf(fd, " %h %h %h %h", a, b, t0, e);
                exp_addr.push_back(e);
                exp_mdata.push_back(t0[7:0]);
                exp_by_md[t0[7:0]] = e;
                send_request(a, b[0], t0[7:0]);
            end
            else if (kind == "W")
                drain_and_check();
            else if (kind == "F")
            begin
                n = $fscanf(fd, " %h", a);
                bp_en = a[0];
            end
            else if (kind == "X")
            begin
                n = $fscanf(fd, " %h %h", a, b);
                absent_page(a, b[7:0]);
            end
            else
                abort("unknown record in the data file");
        end
        $fclose(fd);
        check("walker read count nonzero", walk_count > 0, 1'b1);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- src.f
src/vtp_pkg.sv
src/tlb_cache.sv
src/pt_walker.sv
src/req_pipe.sv
src/vtp_shim.sv
tests/host_mem_model.sv
tests/tb_vtp.sv

//--- Makefile
SIM = obj_dir/Vtb_vtp

.PHONY: all run clean

all: run

$(SIM): src.f src/*.sv tests/*.sv
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_vtp -o Vtb_vtp

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q ">>> PASS"

clean:
	rm -rf obj_dir

//--- tests/vtp_tests.txt
# Records: B base | P line_idx next tag0 pa0 tag1 pa1 | R addr virtual mdata expected_addr
# W drains and checks issued requests | F back-pressure 0/1 | X absent page addr mdata
B 00100000
P 005 101 00001 12345 00002 0abcd
P 101 000 00003 54321 00000 00000
P 020 000 00007 00777 00000 00000
R 00abc000 0 01 00abc000
R 00004143 1 02 0048d143
W
R 00004150 1 03 0048d150
R 0000817f 1 04 002af37f
W
R 0000c16a 1 05 0150c86a
W
F 1
R 0001c801 1 06 0001ddc1
R 00123456 0 07 00123456
R 00004143 1 08 0048d143
R 0000c16a 1 09 0150c86a
R 00fedcba 0 0a 00fedcba
R 0000817f 1 0b 002af37f
R 00000040 0 0c 00000040
W
F 0
X 00024800 0d
